//--- src.f
rtl/modmul_pkg.sv
rtl/modmul_lane.sv
rtl/job_dispatch.sv
rtl/result_collect.sv
rtl/modmul_farm.sv
tb/tb_modmul_farm.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the modmul farm testbench, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_modmul_farm \
    -f src.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/tb_modmul_farm.sv
`timescale 1ns/1ps

module tb_modmul_farm
    import modmul_pkg::*;
();

    localparam int TAGS            = 2 ** TAG_W;
    localparam int RANDOM_JOBS     = 40;
    localparam int JOB_COUNT       = 3 + LANES + RANDOM_JOBS;
    localparam int WATCHDOG_CYCLES = JOB_COUNT * 2 * 257 + 2000;
    localparam int SMALL_LATENCY   = 2 * 4 + 1;

    logic       i_clk;
    logic       i_rst;
    logic       i_start;
    mm_job_t    i_job;
    logic       o_full;
    logic       o_res_valid;
    mm_result_t o_res;

    integer           seed;
    string            cur_test;
    int               chk_errs;
    int               mon_errs = 0;
    int               err_mark;
    int               tests_passed;
    int               tests_failed;
    int               issued_total;
    int               rx_total = 0;
    logic [TAG_W-1:0] next_tag;

    // scoreboard indexed by tag
    logic [OP_W-1:0]  exp_prod [TAGS];
    logic             sent [TAGS];
    int               recv_cnt [TAGS] = '{default: 0};

    modmul_farm uut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_job       (i_job),
        .o_full      (o_full),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic [OP_W-1:0] rand_operand();
        logic [OP_W-1:0] v;
        v = '0;
        for (int i = 0; i < OP_W / 32; i++) begin
            v = {v[OP_W-33:0], rand_word()};
        end
        return v;
    endfunction

    // odd and at least 2^255
    function automatic logic [OP_W-1:0] random_modulus();
        logic [OP_W-1:0] n;
        n           = rand_operand();
        n[OP_W-1]   = 1'b1;
        n[0]        = 1'b1;
        return n;
    endfunction

    // (a mod 2^(k+1)) * b mod n
    function automatic logic [OP_W-1:0] expected_product(
        input logic [A_W-1:0]   a,
        input logic [OP_W-1:0]  b,
        input logic [OP_W-1:0]  n,
        input logic [CNT_W-1:0] k
    );
        logic [A_W-1:0]      mask;
        logic [A_W+OP_W-1:0] prod;
        logic [A_W+OP_W-1:0] rem;
        if (k >= 9'd256) begin
            mask = '1;
        end else begin
            mask = (A_W'(1) << (k + 1'b1)) - A_W'(1);
        end
        prod = {{OP_W{1'b0}}, a & mask} * {{A_W{1'b0}}, b};
        rem  = prod % {{A_W{1'b0}}, n};
        return rem[OP_W-1:0];
    endfunction

    task automatic check_value(input string what, input logic [OP_W-1:0] expected,
                               input logic [OP_W-1:0] actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
            chk_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = chk_errs + mon_errs;
    endtask

    task automatic end_test();
        if (chk_errs + mon_errs == err_mark) begin
            tests_passed++;
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: fail (%0d errors)", cur_test, chk_errs + mon_errs - err_mark);
        end
    endtask

    // called at a falling edge, returns at the falling edge after the start edge
    task automatic issue_job(input logic [A_W-1:0] a, input logic [OP_W-1:0] b,
                             input logic [OP_W-1:0] n, input logic [CNT_W-1:0] k);
        while (o_full) begin
            @(negedge i_clk);
        end
        i_start            = 1'b1;
        i_job.tag          = '0;
        i_job.n            = n;
        i_job.a            = a;
        i_job.b            = b;
        i_job.k            = k;
        exp_prod[next_tag] = expected_product(a, b, n, k);
        sent[next_tag]     = 1'b1;
        next_tag           = next_tag + 1'b1;
        issued_total++;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic issue_random_job(input logic [CNT_W-1:0] k);
        logic [OP_W-1:0] n;
        logic [OP_W-1:0] b;
        logic [31:0]     r;
        n = random_modulus();
        b = rand_operand() % n;
        r = rand_word();
        issue_job({r[0], rand_operand()}, b, n, k);
    endtask

    task automatic wait_drain();
        do begin
            @(posedge i_clk);
        end while (rx_total != issued_total);
        @(negedge i_clk);
    endtask

    task automatic test_single_small();
        int cyc;
        issue_job(A_W'(13), OP_W'(7), OP_W'(101), 9'd3);
        cyc = 0;
        while (!o_res_valid && cyc < 4 * SMALL_LATENCY) begin
            @(negedge i_clk);
            cyc++;
        end
        if (!o_res_valid) begin
            $display("test %s: no result appeared after the start", cur_test);
            chk_errs++;
        end else begin
            check_value("latency", OP_W'(SMALL_LATENCY), OP_W'(cyc));
            check_value("tag", '0, OP_W'(o_res.tag));
            check_value("product", OP_W'(91), o_res.product);
        end
        wait_drain();
    endtask

    task automatic test_preprocess();
        logic [OP_W-1:0]     n;
        logic [OP_W-1:0]     b;
        logic [A_W+OP_W-1:0] direct;
        logic [TAG_W-1:0]    tag;
        n      = random_modulus();
        b      = rand_operand() % n;
        direct = {1'b0, b, {OP_W{1'b0}}} % {{A_W{1'b0}}, n};
        tag    = next_tag;
        issue_job(A_W'(1) << OP_W, b, n, 9'd256);
        // the result must equal b*2^256 mod n
        exp_prod[tag] = direct[OP_W-1:0];
        wait_drain();
    endtask

    task automatic test_full_farm();
        int accepted;
        accepted = 0;
        while (!o_full && accepted <= LANES) begin
            issue_random_job(9'd256);
            accepted++;
        end
        check_value("jobs accepted until full", OP_W'(LANES), OP_W'(accepted));
        // this start must be dropped
        i_start = 1'b1;
        i_job.n = random_modulus();
        i_job.k = 9'd3;
        @(negedge i_clk);
        i_start = 1'b0;
        check_value("o_full after dropped start", OP_W'(1), OP_W'(o_full));
        wait_drain();
        // a tag gap would show up as an unexpected tag here
        issue_random_job(9'd5);
        wait_drain();
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        for (int j = 0; j < RANDOM_JOBS; j++) begin
            r = {$random(seed)} % 257;
            issue_random_job(r[CNT_W-1:0]);
        end
        wait_drain();
        for (int t = 0; t < issued_total; t++) begin
            check_value("results for one tag", OP_W'(1), OP_W'(recv_cnt[t]));
        end
    endtask

    // result checker against the scoreboard
    always @(negedge i_clk) begin
        if (!i_rst && o_res_valid) begin
            assert (sent[o_res.tag] && recv_cnt[o_res.tag] == 0) else begin
                $display("test %s: result with tag %0d was not expected", cur_test, o_res.tag);
                mon_errs++;
            end
            assert (o_res.product == exp_prod[o_res.tag]) else begin
                $display("[ERROR] %s: tag %0d expected %0d actual %0d", cur_test, o_res.tag,
                         exp_prod[o_res.tag], o_res.product);
                mon_errs++;
            end
            recv_cnt[o_res.tag]++;
            rx_total++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed         = 32'h8a03_7d52;
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_job        = '0;
        next_tag     = '0;
        issued_total = 0;
        chk_errs     = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int t = 0; t < TAGS; t++) begin
            sent[t] = 1'b0;
        end
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);

        begin_test("reset_state");
        check_value("o_full", '0, OP_W'(o_full));
        check_value("o_res_valid", '0, OP_W'(o_res_valid));
        end_test();

        begin_test("single_small_job");
        test_single_small();
        end_test();

        begin_test("preprocessing_form");
        test_preprocess();
        end_test();

        begin_test("full_farm");
        test_full_farm();
        end_test();

        begin_test("random_stream");
        test_random_stream();
        end_test();

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, chk_errs + mon_errs);
        if (tests_failed == 0 && chk_errs + mon_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- rtl/modmul_farm.sv
`timescale 1ns/1ps

module modmul_farm
    import modmul_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_start,
    input  mm_job_t    i_job,
    output logic       o_full,
    output logic       o_res_valid,
    output mm_result_t o_res
);

    logic [LANES-1:0] lane_load;
    logic [LANES-1:0] lane_idle;
    logic [LANES-1:0] lane_hold;
    logic [LANES-1:0] lane_ack;
    mm_job_t          lane_job;
    mm_result_t       lane_result [LANES];

    job_dispatch u_dispatch (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (i_start),
        .i_job   (i_job),
        .i_idle  (lane_idle),
        .o_load  (lane_load),
        .o_job   (lane_job),
        .o_full  (o_full)
    );

    // all lanes share the job bus, load strobe selects one
    genvar g;
    generate
        for (g = 0; g < LANES; g++) begin : g_lane
            modmul_lane u_lane (
                .i_clk    (i_clk),
                .i_rst    (i_rst),
                .i_load   (lane_load[g]),
                .i_job    (lane_job),
                .i_ack    (lane_ack[g]),
                .o_idle   (lane_idle[g]),
                .o_hold   (lane_hold[g]),
                .o_result (lane_result[g])
            );
        end
    endgenerate

    result_collect u_collect (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_hold      (lane_hold),
        .i_result    (lane_result),
        .o_ack       (lane_ack),
        .o_res_valid (o_res_valid),
        .o_res       (o_res)
    );

endmodule

//--- rtl/result_collect.sv
`timescale 1ns/1ps

module result_collect
    import modmul_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [LANES-1:0] i_hold,
    input  mm_result_t       i_result [LANES],
    output logic [LANES-1:0] o_ack,
    output logic             o_res_valid,
    output mm_result_t       o_res
);

    logic [LANES-1:0] sel;
    logic             any_hold;
    mm_result_t       sel_res;
    logic             res_valid_r;
    mm_result_t       res_r;

    // one lane per cycle, lowest index first
    assign sel      = pick_lowest(i_hold);
    assign any_hold = |i_hold;
    assign o_ack    = sel;

    always_comb begin
        sel_res = '0;
        for (int i = 0; i < LANES; i++) begin
            if (sel[i]) begin
                sel_res = i_result[i];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            res_valid_r <= 1'b0;
        end else begin
            res_valid_r <= any_hold;
        end
    end

    always_ff @(posedge i_clk) begin
        if (any_hold) begin
            res_r <= sel_res;
        end
    end

    assign o_res_valid = res_valid_r;
    assign o_res       = res_r;

endmodule

//--- rtl/job_dispatch.sv
`timescale 1ns/1ps

module job_dispatch
    import modmul_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  mm_job_t          i_job,
    input  logic [LANES-1:0] i_idle,
    output logic [LANES-1:0] o_load,
    output mm_job_t          o_job,
    output logic             o_full
);

    logic [TAG_W-1:0] tag_r;
    logic [LANES-1:0] free_pick;
    logic             accept;

    // lowest idle lane wins
    assign free_pick = pick_lowest(i_idle);

    assign o_full = ~|i_idle;
    assign accept = i_start & ~o_full;
    assign o_load = accept ? free_pick : '0;

    // shared job bus, restamped with the sequence tag
    always_comb begin
        o_job     = i_job;
        o_job.tag = tag_r;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            tag_r <= '0;
        end else if (accept) begin
            tag_r <= tag_r + 1'b1;
        end
    end

endmodule

//--- rtl/modmul_lane.sv
`timescale 1ns/1ps

module modmul_lane
    import modmul_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_load,
    input  mm_job_t    i_job,
    input  logic       i_ack,
    output logic       o_idle,
    output logic       o_hold,
    output mm_result_t o_result
);

    lane_state_e      state_r, state_w;
    logic [CNT_W-1:0] idx_r, idx_w;
    logic [OP_W-1:0]  acc_r, acc_w;
    logic [OP_W-1:0]  dbl_r, dbl_w;

    // job fields captured at load
    logic [OP_W-1:0]  n_r;
    logic [A_W-1:0]   a_r;
    logic [CNT_W-1:0] k_r;
    logic [TAG_W-1:0] tag_r;

    logic [OP_W:0]    add_sum;
    logic [OP_W:0]    dbl_sum;

    // both inputs are below m, so one subtraction is enough
    function automatic logic [OP_W-1:0] mod_reduce(
        input logic [OP_W:0]   s,
        input logic [OP_W-1:0] m
    );
        logic [OP_W:0] diff;
        diff = s - {1'b0, m};
        if (s >= {1'b0, m}) begin
            return diff[OP_W-1:0];
        end
        return s[OP_W-1:0];
    endfunction

    assign add_sum = {1'b0, acc_r} + {1'b0, dbl_r};
    assign dbl_sum = {dbl_r, 1'b0};

    assign o_idle           = (state_r == LANE_IDLE);
    assign o_hold           = (state_r == LANE_HOLD);
    assign o_result.tag     = tag_r;
    assign o_result.product = acc_r;

    always_comb begin
        state_w = state_r;
        idx_w   = idx_r;
        acc_w   = acc_r;
        dbl_w   = dbl_r;
        case (state_r)
            LANE_IDLE: begin
                state_w = LANE_IDLE;
            end
            LANE_ADD: begin
                if (a_r[idx_r]) begin
                    acc_w = mod_reduce(add_sum, n_r);
                end
                dbl_w   = mod_reduce(dbl_sum, n_r);
                state_w = LANE_STEP;
            end
            LANE_STEP: begin
                if (idx_r == k_r) begin
                    state_w = LANE_HOLD;
                end else begin
                    idx_w   = idx_r + 1'b1;
                    state_w = LANE_ADD;
                end
            end
            LANE_HOLD: begin
                if (i_ack) begin
                    state_w = LANE_IDLE;
                end
            end
        endcase
        // dispatcher only loads idle lanes
        if (i_load) begin
            state_w = LANE_ADD;
            idx_w   = '0;
            acc_w   = '0;
            dbl_w   = i_job.b;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r <= LANE_IDLE;
        end else begin
            state_r <= state_w;
        end
    end

    always_ff @(posedge i_clk) begin
        idx_r <= idx_w;
        acc_r <= acc_w;
        dbl_r <= dbl_w;
        if (i_load) begin
            n_r   <= i_job.n;
            a_r   <= i_job.a;
            k_r   <= i_job.k;
            tag_r <= i_job.tag;
        end
    end

endmodule

//--- rtl/modmul_pkg.sv
package modmul_pkg;

    localparam int LANES = 4;
    localparam int OP_W  = 256;
    localparam int A_W   = OP_W + 1;
    localparam int CNT_W = 9;
    localparam int TAG_W = 8;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_ADD  = 2'd1,
        LANE_STEP = 2'd2,
        LANE_HOLD = 2'd3
    } lane_state_e;

    // one modular product request
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [OP_W-1:0]  n;
        logic [A_W-1:0]   a;
        logic [OP_W-1:0]  b;
        logic [CNT_W-1:0] k;
    } mm_job_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [OP_W-1:0]  product;
    } mm_result_t;

    // one-hot of the lowest set request bit, zero if none
    function automatic logic [LANES-1:0] pick_lowest(input logic [LANES-1:0] req);
        logic [LANES-1:0] pick;
        pick = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
        return pick;
    endfunction

endpackage
